// ==== verification/upsize_input.txt ====
// Columns: tag, data, strobes, last (hex); N is a narrow beat to drive
// W is the expected wide beat, data written lane 3 down to lane 0
// Full packing, then last on the fourth beat
N 11111111 f 0
N 22222222 f 0
N 33333333 f 0
N 44444444 f 0
W 44444444333333332222222211111111 ffff 0
N a0a0a0a0 f 0
N b1b1b1b1 f 0
N c2c2c2c2 f 0
N d3d3d3d3 f 1
W d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0 ffff 1
// Early last after one, two and three beats
N 0badf00d f 1
W 0000000000000000000000000badf00d 000f 1
N 12345678 f 0
N 9abcdef0 f 1
W 00000000000000009abcdef012345678 00ff 1
N cafe0001 f 0
N cafe0002 f 0
N cafe0003 f 1
W 00000000cafe0003cafe0002cafe0001 0fff 1
// Burst of five crosses into a second wide beat
N 50000001 f 0
N 50000002 f 0
N 50000003 f 0
N 50000004 f 0
W 50000004500000035000000250000001 ffff 0
N 50000005 f 1
W 00000000000000000000000050000005 000f 1
// Partial and zero strobes
N deadbeef 1 0
N 01020304 0 0
N aabbccdd 6 0
N 55667788 8 1
W 55667788aabbccdd01020304deadbeef 8601 1
N 11223344 3 0
N 99887766 c 0
N 00000000 0 1
W 00000000000000009988776611223344 00c3 1
// Longer burst for back-pressure
N 60000000 f 0
N 60000001 f 0
N 60000002 f 0
N 60000003 f 0
W 60000003600000026000000160000000 ffff 0
N 60000004 f 0
N 60000005 f 0
N 60000006 f 0
N 60000007 f 1
W 60000007600000066000000560000004 ffff 1

// ==== vlog.f ====
source/axi_width_pkg.sv
source/wbeat_pkg.sv
source/wdata_ingress.sv
source/wdata_upsize_accum.sv
source/wide_beat_fifo.sv
source/wdata_upsizer_top.sv
verification/tb_wdata_upsizer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the upsizer testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -j 0 \
    --top-module tb_wdata_upsizer -Mdir obj_dir -f vlog.f
./obj_dir/Vtb_wdata_upsizer

// ==== verification/tb_wdata_upsizer.sv ====
// Testbench for the W channel upsizer with file stimulus, random stalls, checks and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_wdata_upsizer import axi_width_pkg::*; import wbeat_pkg::*; ();

    // Cycles with aresetn low
    localparam int reset_cycles_c = 16;
    // Idle cycles after the last expected beat with no wide beat allowed
    localparam int drain_cycles_c = 20;
    localparam logic [31:0] seed_c = 32'd66;

    logic         aclk = 1'b0;
    logic         aresetn;
    logic         narrow_valid;
    logic         narrow_ready;
    narrow_beat_t narrow_beat;
    logic         wide_valid;
    logic         wide_ready;
    wide_beat_t   wide_beat;

    // Beats from the data file in file order
    narrow_beat_t narrow_q[$];
    wide_beat_t   expect_q[$];

    int cycle_count  = 0;
    int cycle_limit  = 0;
    int beats_seen   = 0;
    bit reset_done   = 1'b0;
    bit monitor_done = 1'b0;

    wdata_upsizer_top uut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .narrow_valid (narrow_valid),
        .narrow_ready (narrow_ready),
        .narrow_beat  (narrow_beat),
        .wide_valid   (wide_valid),
        .wide_ready   (wide_ready),
        .wide_beat    (wide_beat)
    );

    // 10 ns period
    always #5 aclk = ~aclk;

    // ==========================================================
    // Helpers
    // ==========================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_wide_data(input wide_data_t got, input wide_data_t exp);
        if (got !== exp) begin
            $display("Error: wide_beat.data of beat %0d is %h, expected %h", beats_seen, got, exp);
            abort_run("Wide data does not match the expected lanes");
        end
    endtask

    task automatic check_wide_strb(input wide_strb_t got, input wide_strb_t exp);
        if (got !== exp) begin
            $display("Error: wide_beat.strb of beat %0d is %h, expected %h", beats_seen, got, exp);
            abort_run("Wide strobes do not match the expected lanes");
        end
    endtask

    task automatic check_wide_last(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: wide_beat.last of beat %0d is %h, expected %h", beats_seen, got, exp);
            abort_run("Wide last bit is wrong");
        end
    endtask

    // Handshake flags outside of a transfer
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            abort_run("Handshake flag has the wrong level");
        end
    endtask

    // N lines go to the driver and W lines to the expected queue
    task automatic load_vectors();
        int           fd;
        int           code;
        string        line;
        narrow_data_t n_data;
        narrow_strb_t n_strb;
        wide_data_t   w_data;
        wide_strb_t   w_strb;
        logic         b_last;
        fd = $fopen("verification/upsize_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/upsize_input.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1) begin
                if (line.getc(0) == "N") begin
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                                   n_data, n_strb, b_last);
                    if (code != 3) begin
                        abort_run("A narrow beat line in the data file is malformed");
                    end
                    narrow_q.push_back('{data: n_data, strb: n_strb, last: b_last});
                end else if (line.getc(0) == "W") begin
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                                   w_data, w_strb, b_last);
                    if (code != 3) begin
                        abort_run("A wide beat line in the data file is malformed");
                    end
                    expect_q.push_back('{data: w_data, strb: w_strb, last: b_last});
                end
            end
        end
        $fclose(fd);
    endtask

    // ==========================================================
    // Reset, timeout and end of run
    // ==========================================================

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("The run timed out after %0d cycles", cycle_count));
        end
    end

    initial begin : run_control
        aresetn = 1'b0;
        load_vectors();
        cycle_limit = 20 * narrow_q.size() + 200;
        // Idle handshake levels while in reset
        repeat (reset_cycles_c) begin
            @(negedge aclk);
            check_flag("wide_valid", wide_valid, 1'b0);
            check_flag("narrow_ready", narrow_ready, 1'b1);
        end
        aresetn = 1'b1;
        @(negedge aclk);
        check_flag("wide_valid", wide_valid, 1'b0);
        check_flag("narrow_ready", narrow_ready, 1'b1);
        reset_done = 1'b1;
        wait (monitor_done);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // ==========================================================
    // Narrow driver
    // ==========================================================

    initial begin : narrow_driver
        logic [31:0]  rnd;
        int           gap;
        narrow_beat_t beat;
        narrow_valid = 1'b0;
        narrow_beat  = '0;
        rnd = seed_c;
        wait (reset_done);
        while (narrow_q.size() > 0) begin
            beat = narrow_q.pop_front();
            rnd = xorshift32(rnd);
            // Roughly one beat in four waits a few idle cycles
            gap = 0;
            if (rnd[3:2] == 2'b00) begin
                gap = int'(rnd % 3) + 1;
            end
            if (gap > 0) begin
                narrow_valid = 1'b0;
                repeat (gap) @(negedge aclk);
            end
            narrow_valid = 1'b1;
            narrow_beat  = beat;
            // Ready is a flop output and stays stable up to the next rising edge
            while (!narrow_ready) @(negedge aclk);
            @(negedge aclk);
        end
        narrow_valid = 1'b0;
    end

    // ==========================================================
    // Wide monitor with random back-pressure
    // ==========================================================

    initial begin : wide_monitor
        logic [31:0] rnd;
        int          run_left;
        wide_beat_t  exp;
        wide_ready = 1'b0;
        rnd = {seed_c[15:0], seed_c[31:16]};
        run_left = 0;
        wait (reset_done);
        while (expect_q.size() > 0) begin
            // Ready holds one level for a run of 1 to 16 cycles
            if (run_left == 0) begin
                rnd = xorshift32(rnd);
                run_left = int'(rnd % 16) + 1;
                wide_ready = rnd[20];
            end
            run_left = run_left - 1;
            // Transfer happens on the next rising edge
            if (wide_valid && wide_ready) begin
                exp = expect_q.pop_front();
                check_wide_data(wide_beat.data, exp.data);
                check_wide_strb(wide_beat.strb, exp.strb);
                check_wide_last(wide_beat.last, exp.last);
                beats_seen = beats_seen + 1;
            end
            @(negedge aclk);
        end
        // No extra or empty wide beat after the last one
        wide_ready = 1'b1;
        repeat (drain_cycles_c) begin
            check_flag("wide_valid", wide_valid, 1'b0);
            @(negedge aclk);
        end
        monitor_done = 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/wdata_upsizer_top.sv ====
// W channel upsizer top with input stage, accumulator and output FIFO
`timescale 1ns/10ps
`default_nettype none

module wdata_upsizer_top import wbeat_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    // Narrow W from the slave
    input  logic         narrow_valid,
    output logic         narrow_ready,
    input  narrow_beat_t narrow_beat,
    // Wide W toward the master
    output logic         wide_valid,
    input  logic         wide_ready,
    output wide_beat_t   wide_beat
);

    // Wide beats buffered before the master
    localparam int fifo_depth_c = 4;

    // ==========================================================
    // Internal links
    // ==========================================================

    // Input stage to accumulator
    logic         in_valid;
    logic         in_ready;
    narrow_beat_t in_beat;

    // Accumulator to FIFO
    logic         acc_valid;
    logic         acc_ready;
    wide_beat_t   acc_beat;

    // ==========================================================
    // Stages
    // ==========================================================

    wdata_ingress u_ingress (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .narrow_valid (narrow_valid),
        .narrow_ready (narrow_ready),
        .narrow_beat  (narrow_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_beat      (in_beat)
    );

    wdata_upsize_accum u_accum (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .acc_valid (acc_valid),
        .acc_ready (acc_ready),
        .acc_beat  (acc_beat)
    );

    wide_beat_fifo #(
        .fifo_depth (fifo_depth_c)
    ) u_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .acc_valid  (acc_valid),
        .acc_ready  (acc_ready),
        .acc_beat   (acc_beat),
        .wide_valid (wide_valid),
        .wide_ready (wide_ready),
        .wide_beat  (wide_beat)
    );

endmodule

`default_nettype wire

// ==== source/wide_beat_fifo.sv ====
// Circular FIFO of wide W beats between the accumulator and the master
`timescale 1ns/10ps
`default_nettype none

module wide_beat_fifo import wbeat_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic       aclk,
    input  logic       aresetn,
    // Write side from the accumulator
    input  logic       acc_valid,
    output logic       acc_ready,
    input  wide_beat_t acc_beat,
    // Read side toward the master
    output logic       wide_valid,
    input  logic       wide_ready,
    output wide_beat_t wide_beat
);

    localparam int ptr_w_c = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w_c = $clog2(fifo_depth + 1);

    typedef logic [ptr_w_c-1:0] ptr_t;
    typedef logic [cnt_w_c-1:0] cnt_t;

    // ==========================================================
    // Storage and pointers
    // ==========================================================

    wide_beat_t mem [fifo_depth];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    // Occupancy in wide beats
    cnt_t       count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full  = (count == cnt_t'(fifo_depth));
    assign rd_en = wide_valid && wide_ready;
    assign wr_en = acc_valid && acc_ready;

    // A full FIFO still takes a beat when the head leaves
    assign acc_ready = !full || wide_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write keeps the count
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entries hold payload only
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= acc_beat;
        end
    end

    // ==========================================================
    // Head
    // ==========================================================

    // Head comes from stored entries, one cycle after the write
    assign wide_valid = (count != '0);
    assign wide_beat  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/wdata_upsize_accum.sv ====
// Packs four narrow W beats into one wide W beat with early finish on last
`timescale 1ns/10ps
`default_nettype none

module wdata_upsize_accum import axi_width_pkg::*; import wbeat_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    // Narrow beats from the input stage
    input  logic         in_valid,
    output logic         in_ready,
    input  narrow_beat_t in_beat,
    // Finished wide beats toward the FIFO
    output logic         acc_valid,
    input  logic         acc_ready,
    output wide_beat_t   acc_beat
);

    // Strobe bits per narrow lane
    localparam int strb_w_c = $bits(narrow_strb_t);

    // ==========================================================
    // Accumulator state
    // ==========================================================

    wide_data_t acc_data;
    wide_strb_t acc_strb;
    logic       acc_last;
    // Lane that the next accepted narrow beat goes into
    lane_idx_t  lane_ptr;
    // Finished wide beat waiting for the FIFO
    logic       held;

    logic       accept;
    logic       first_beat;
    logic       finish;
    logic       hand_over;
    wide_data_t data_next;
    wide_strb_t strb_next;

    assign accept     = in_valid && in_ready;
    assign first_beat = (lane_ptr == '0);
    // Fourth lane filled, or the burst ends early
    assign finish     = (lane_ptr == lane_idx_t'(width_ratio_c - 1)) || in_beat.last;
    assign hand_over  = held && acc_ready;

    // Stall only while a finished beat is stuck
    assign in_ready = !held || acc_ready;

    // ==========================================================
    // Lane insertion
    // ==========================================================

    always_comb begin
        data_next = acc_data;
        strb_next = acc_strb;
        // A new wide beat starts with empty lanes
        if (first_beat) begin
            data_next = '0;
            strb_next = '0;
        end
        data_next[lane_ptr*narrow_width_c +: narrow_width_c] = in_beat.data;
        strb_next[lane_ptr*strb_w_c +: strb_w_c] = in_beat.strb;
    end

    // ==========================================================
    // Control
    // ==========================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lane_ptr <= '0;
            held     <= 1'b0;
        end else begin
            if (accept) begin
                if (finish) begin
                    lane_ptr <= '0;
                    held     <= 1'b1;
                end else begin
                    lane_ptr <= lane_ptr + 1'b1;
                    // FIFO may take the old beat while a new one starts
                    if (hand_over) begin
                        held <= 1'b0;
                    end
                end
            end else if (hand_over) begin
                held <= 1'b0;
            end
        end
    end

    // Payload, old beat leaves on the same edge it gets overwritten
    always_ff @(posedge aclk) begin
        if (accept) begin
            acc_data <= data_next;
            acc_strb <= strb_next;
            if (finish) begin
                acc_last <= in_beat.last;
            end
        end
    end

    assign acc_valid     = held;
    assign acc_beat.data = acc_data;
    assign acc_beat.strb = acc_strb;
    assign acc_beat.last = acc_last;

endmodule

`default_nettype wire

// ==== source/wdata_ingress.sv ====
// Narrow W beat input stage with a main register and a skid register
`timescale 1ns/10ps
`default_nettype none

module wdata_ingress import wbeat_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    // Narrow W from the slave
    input  logic         narrow_valid,
    output logic         narrow_ready,
    input  narrow_beat_t narrow_beat,
    // Registered beat toward the accumulator
    output logic         in_valid,
    input  logic         in_ready,
    output narrow_beat_t in_beat
);

    // ==========================================================
    // Storage
    // ==========================================================

    logic         main_valid;
    narrow_beat_t main_beat;
    // Skid entry is empty after reset, so ready starts high
    logic         skid_empty;
    narrow_beat_t skid_beat;

    logic push;
    logic main_free;

    // Slave handshake on this edge
    assign push = narrow_valid && skid_empty;
    // Main register can take a new beat when empty or draining
    assign main_free = !main_valid || in_ready;

    // ==========================================================
    // Control
    // ==========================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            main_valid <= 1'b0;
            skid_empty <= 1'b1;
        end else begin
            if (main_free) begin
                // Skid beat is older, it moves first
                main_valid <= !skid_empty || push;
                skid_empty <= 1'b1;
            end else if (push) begin
                // Downstream stalled, park the beat
                skid_empty <= 1'b0;
            end
        end
    end

    // Payload follows the same selection as the control path
    always_ff @(posedge aclk) begin
        if (main_free) begin
            if (!skid_empty) begin
                main_beat <= skid_beat;
            end else if (push) begin
                main_beat <= narrow_beat;
            end
        end else if (push) begin
            skid_beat <= narrow_beat;
        end
    end

    // Ready is a flop output, no path from in_ready
    assign narrow_ready = skid_empty;
    assign in_valid     = main_valid;
    assign in_beat      = main_beat;

endmodule

`default_nettype wire

// ==== source/wbeat_pkg.sv ====
// Packed W beat structs for the narrow and the wide side of the upsizer
`default_nettype none

package wbeat_pkg;

    import axi_width_pkg::*;

    // ==========================================================
    // W channel beats
    // ==========================================================

    // One 32-bit beat as it arrives from the slave
    typedef struct packed {
        narrow_data_t data;
        narrow_strb_t strb;
        logic         last;
    } narrow_beat_t;

    // One 128-bit beat as it leaves toward the master
    // Lane k of data and strb holds narrow beat k
    typedef struct packed {
        wide_data_t data;
        wide_strb_t strb;
        logic       last;
    } wide_beat_t;

endpackage

`default_nettype wire

// ==== source/axi_width_pkg.sv ====
// Data, strobe and lane widths of the 32 to 128 bit W channel upsizer
`default_nettype none

package axi_width_pkg;

    // ==========================================================
    // Bus widths
    // ==========================================================

    // Narrow side toward the slave
    localparam int narrow_width_c = 32;

    // Wide side toward the master
    localparam int wide_width_c = 128;

    // Narrow beats packed into one wide beat
    localparam int width_ratio_c = wide_width_c / narrow_width_c;

    // ==========================================================
    // Vector types
    // ==========================================================

    typedef logic [narrow_width_c-1:0]   narrow_data_t;
    typedef logic [narrow_width_c/8-1:0] narrow_strb_t;
    typedef logic [wide_width_c-1:0]     wide_data_t;
    typedef logic [wide_width_c/8-1:0]   wide_strb_t;

    // Selects one narrow lane inside a wide beat
    typedef logic [$clog2(width_ratio_c)-1:0] lane_idx_t;

endpackage

`default_nettype wire
